//--- files.f
source/chip_ctrl_pkg.sv
source/chip_ctrl_decode.sv
source/clk_ctrl_regs.sv
source/pad_cfg_regs.sv
source/chip_ctrl_top.sv
bench/tb_chip_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# Build the chip control testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
  --top-module tb_chip_ctrl \
  -f files.f \
  -o tb_chip_ctrl

./obj_dir/tb_chip_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
  exit 0
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi

//--- bench/tb_chip_ctrl.sv
// Testbench for chip_ctrl_top with clock, reset, watchdog, bus tasks, compare tasks and directed tests
`timescale 1ns/100ps

module tb_chip_ctrl import chip_ctrl_pkg::*; ();

  ////////////////////////////////////////////////////////////
  // Run limits and response codes
  ////////////////////////////////////////////////////////////
  localparam int CLK_PERIOD      = 10;
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 200;
  localparam int BUS_TIMEOUT     = 20;

  typedef logic [1:0] resp_t;
  localparam resp_t RESP_NONE = 2'd0;
  localparam resp_t RESP_ACK  = 2'd1;
  localparam resp_t RESP_ERR  = 2'd2;

  logic         soc_clk;
  logic         rst;
  logic         wb_cyc;
  logic         wb_stb;
  logic         wb_we;
  wb_addr_t     wb_adr;
  wb_data_t     wb_dat_w;
  wb_data_t     wb_dat_r;
  logic         wb_ack;
  logic         wb_err;
  logic         pad_clk_byp;
  logic         jtag_clk_byp;
  clk_dom_vec_t clk_en;
  clk_dom_vec_t clk_byp;
  pad_vec_t     gpio_out;
  pad_vec_t     gpio_oe;
  timer_vec_t   timer_ch;
  pad_vec_t     pad_in;
  pad_vec_t     pad_out;
  pad_vec_t     pad_oe;
  pad_vec_t     gpio_in;

  // Model of the register contents
  clk_dom_vec_t exp_en;
  clk_dom_vec_t exp_byp;
  pad_func_t    exp_func [NUM_PADS];

  integer seed;
  string  test_name;
  int     error_count;
  int     errors_at_start;
  int     tests_run;
  int     tests_failed;

  chip_ctrl_top dut (
    .soc_clk_i      ( soc_clk      ),
    .rst_i          ( rst          ),
    .wb_cyc_i       ( wb_cyc       ),
    .wb_stb_i       ( wb_stb       ),
    .wb_we_i        ( wb_we        ),
    .wb_adr_i       ( wb_adr       ),
    .wb_dat_i       ( wb_dat_w     ),
    .wb_dat_o       ( wb_dat_r     ),
    .wb_ack_o       ( wb_ack       ),
    .wb_err_o       ( wb_err       ),
    .pad_clk_byp_i  ( pad_clk_byp  ),
    .jtag_clk_byp_i ( jtag_clk_byp ),
    .clk_en_o       ( clk_en       ),
    .clk_byp_o      ( clk_byp      ),
    .gpio_out_i     ( gpio_out     ),
    .gpio_oe_i      ( gpio_oe      ),
    .timer_ch_i     ( timer_ch     ),
    .pad_in_i       ( pad_in       ),
    .pad_out_o      ( pad_out      ),
    .pad_oe_o       ( pad_oe       ),
    .gpio_in_o      ( gpio_in      )
  );

  // 10 ns clock
  initial soc_clk = 1'b0;
  always #(CLK_PERIOD / 2) soc_clk = ~soc_clk;

  // Watchdog with a fixed budget per test
  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, run did not finish",
             NUM_TESTS * CYCLES_PER_TEST);
    $display("RESULT: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] rand32();
    rand32 = $random(seed);
  endfunction

  // Region in bits 11:8 and word index in bits 7:2
  function automatic wb_addr_t make_addr(input logic [3:0] region, input logic [5:0] idx);
    make_addr = {20'd0, region, idx, 2'b00};
  endfunction

  function automatic string resp_name(input resp_t r);
    case (r)
      RESP_ACK: resp_name = "ack";
      RESP_ERR: resp_name = "err";
      default:  resp_name = "none";
    endcase
  endfunction

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = error_count;
  endtask

  task automatic end_test();
    tests_run++;
    if (error_count == errors_at_start) begin
      $display("test %s: passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, error_count - errors_at_start);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////
  task automatic cmp_data(input wb_data_t exp, input wb_data_t act, input string what);
    if (act !== exp) begin
      $display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
      error_count++;
    end
  endtask

  task automatic cmp_clk(input clk_dom_vec_t exp, input clk_dom_vec_t act, input string what);
    if (act !== exp) begin
      $display("error %s %s: expected %b, actual %b", test_name, what, exp, act);
      error_count++;
    end
  endtask

  task automatic cmp_pad(input pad_vec_t exp, input pad_vec_t act, input string what);
    if (act !== exp) begin
      $display("error %s %s: expected %b, actual %b", test_name, what, exp, act);
      error_count++;
    end
  endtask

  task automatic cmp_resp(input resp_t exp, input resp_t act, input string what);
    if (act !== exp) begin
      $display("error %s %s: expected %s, actual %s", test_name, what,
               resp_name(exp), resp_name(act));
      error_count++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Bus tasks entered and left on a falling edge
  ////////////////////////////////////////////////////////////
  task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t wdat,
                           output wb_data_t rdat, output resp_t resp);
    int waited;
    resp   = RESP_NONE;
    waited = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    while (resp == RESP_NONE && waited < BUS_TIMEOUT) begin
      @(negedge soc_clk);
      waited++;
      if (wb_ack && wb_err) begin
        $display("%s: ack and err both high for address %h", test_name, adr);
        error_count++;
        resp = RESP_ERR;
      end else if (wb_ack) begin
        resp = RESP_ACK;
      end else if (wb_err) begin
        resp = RESP_ERR;
      end
    end
    // Address still held so read data is valid here
    rdat   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    if (resp == RESP_NONE) begin
      $display("%s: no ack or err within %0d cycles for address %h", test_name,
               BUS_TIMEOUT, adr);
      error_count++;
    end else if (waited != 1) begin
      $display("%s: response came %0d cycles after the request instead of one",
               test_name, waited);
      error_count++;
    end
    // Response must be gone one cycle later
    @(negedge soc_clk);
    if (wb_ack || wb_err) begin
      $display("%s: response stayed high for more than one cycle at address %h",
               test_name, adr);
      error_count++;
    end
  endtask

  task automatic wb_write(input wb_addr_t adr, input wb_data_t wdat, output resp_t resp);
    wb_data_t unused;
    bus_cycle(1'b1, adr, wdat, unused, resp);
  endtask

  task automatic wb_read(input wb_addr_t adr, output wb_data_t rdat, output resp_t resp);
    bus_cycle(1'b0, adr, '0, rdat, resp);
  endtask

  ////////////////////////////////////////////////////////////
  // Pad stimulus and checks
  ////////////////////////////////////////////////////////////
  task automatic drive_random_pads();
    logic [31:0] rnd;
    rnd      = rand32();
    gpio_out = rnd[7:0];
    gpio_oe  = rnd[15:8];
    pad_in   = rnd[23:16];
    timer_ch = rnd[27:24];
    @(negedge soc_clk);
  endtask

  // GPIO passes through, timer uses channel k mod 4 and reserved codes are silent
  task automatic check_pads();
    pad_vec_t e_out;
    pad_vec_t e_oe;
    pad_vec_t e_in;
    e_out = '0;
    e_oe  = '0;
    e_in  = '0;
    for (int k = 0; k < NUM_PADS; k++) begin
      if (exp_func[k] == PAD_FUNC_GPIO) begin
        e_out[k] = gpio_out[k];
        e_oe[k]  = gpio_oe[k];
        e_in[k]  = pad_in[k];
      end else if (exp_func[k] == PAD_FUNC_TIMER) begin
        e_out[k] = timer_ch[k % TIMER_CH_COUNT];
        e_oe[k]  = 1'b1;
      end
    end
    cmp_pad(e_out, pad_out, "pad_out_o");
    cmp_pad(e_oe, pad_oe, "pad_oe_o");
    cmp_pad(e_in, gpio_in, "gpio_in_o");
  endtask

  // Reads every register and compares with the model
  task automatic check_all_regs();
    wb_data_t rd;
    wb_data_t exp_word;
    resp_t    resp;
    for (int d = 0; d < NUM_CLK_DOMAINS; d++) begin
      wb_read(make_addr(CLK_CTRL_REGION, 6'(d)), rd, resp);
      cmp_resp(RESP_ACK, resp, "clock register read");
      exp_word = '0;
      exp_word[CLK_EN_BIT]  = exp_en[d];
      exp_word[CLK_BYP_BIT] = exp_byp[d];
      cmp_data(exp_word, rd, "clock register value");
    end
    for (int k = 0; k < NUM_PADS; k++) begin
      wb_read(make_addr(PAD_CFG_REGION, 6'(k)), rd, resp);
      cmp_resp(RESP_ACK, resp, "pad register read");
      exp_word = '0;
      exp_word[1:0] = exp_func[k];
      cmp_data(exp_word, rd, "pad register value");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////
  task automatic test_reset_defaults();
    begin_test("reset_defaults");
    cmp_clk('1, clk_en, "clk_en_o");
    cmp_clk('0, clk_byp, "clk_byp_o");
    repeat (3) begin
      drive_random_pads();
      check_pads();
    end
    check_all_regs();
    end_test();
  endtask

  task automatic test_clk_regs();
    logic [31:0]  rnd;
    logic         base_byp;
    logic [1:0]   combo;
    wb_data_t     rd;
    resp_t        resp;
    clk_dom_vec_t eff;
    begin_test("clk_regs");
    // Neighbouring domains get opposite stored bypass so both values occur
    rnd      = rand32();
    base_byp = rnd[0];
    for (int d = 0; d < NUM_CLK_DOMAINS; d++) begin
      rnd              = rand32();
      exp_en[d]        = rnd[CLK_EN_BIT];
      exp_byp[d]       = base_byp ^ 1'(d);
      rnd[CLK_BYP_BIT] = exp_byp[d];
      wb_write(make_addr(CLK_CTRL_REGION, 6'(d)), rnd, resp);
      cmp_resp(RESP_ACK, resp, "domain write");
    end
    check_all_regs();
    cmp_clk(exp_en, clk_en, "clk_en_o");
    // Status word is read only
    wb_write(make_addr(CLK_CTRL_REGION, CLK_STATUS_IDX), 32'hffff_ffff, resp);
    cmp_resp(RESP_ACK, resp, "status write");
    for (int c = 0; c < 4; c++) begin
      combo        = 2'(c);
      pad_clk_byp  = combo[0];
      jtag_clk_byp = combo[1];
      @(negedge soc_clk);
      eff = exp_byp | {NUM_CLK_DOMAINS{combo[0] | combo[1]}};
      cmp_clk(eff, clk_byp, "clk_byp_o");
      wb_read(make_addr(CLK_CTRL_REGION, CLK_STATUS_IDX), rd, resp);
      cmp_resp(RESP_ACK, resp, "status read");
      cmp_data({29'd0, eff}, rd, "status value");
    end
    pad_clk_byp  = 1'b0;
    jtag_clk_byp = 1'b0;
    check_all_regs();
    end_test();
  endtask

  task automatic test_pad_mux();
    logic [31:0] rnd;
    pad_func_t   base;
    resp_t       resp;
    begin_test("pad_mux");
    // XOR of one random code with the pad number puts every code on some pad
    rnd  = rand32();
    base = rnd[1:0];
    for (int k = 0; k < NUM_PADS; k++) begin
      rnd         = rand32();
      exp_func[k] = base ^ 2'(k);
      wb_write(make_addr(PAD_CFG_REGION, 6'(k)), {rnd[31:2], exp_func[k]}, resp);
      cmp_resp(RESP_ACK, resp, "function write");
    end
    check_all_regs();
    repeat (4) begin
      drive_random_pads();
      check_pads();
    end
    end_test();
  endtask

  task automatic test_unmapped();
    wb_data_t rd;
    resp_t    resp;
    begin_test("unmapped");
    wb_write(make_addr(4'd5, 6'd0), rand32(), resp);
    cmp_resp(RESP_ERR, resp, "region 5 write");
    wb_read(make_addr(4'd5, 6'd1), rd, resp);
    cmp_resp(RESP_ERR, resp, "region 5 read");
    check_all_regs();
    end_test();
  endtask

  task automatic test_bad_index();
    wb_data_t rd;
    resp_t    resp;
    begin_test("bad_index");
    wb_write(make_addr(CLK_CTRL_REGION, 6'd4), 32'h3, resp);
    cmp_resp(RESP_ERR, resp, "clock index 4 write");
    wb_read(make_addr(PAD_CFG_REGION, 6'd9), rd, resp);
    cmp_resp(RESP_ERR, resp, "pad index 9 read");
    wb_write(make_addr(PAD_CFG_REGION, 6'd9), 32'h1, resp);
    cmp_resp(RESP_ERR, resp, "pad index 9 write");
    wb_read(make_addr(CLK_CTRL_REGION, CLK_STATUS_IDX), rd, resp);
    cmp_resp(RESP_ACK, resp, "status read");
    check_all_regs();
    end_test();
  endtask

  // Mixed reads with timing checked inside every bus cycle
  task automatic test_timing();
    logic [31:0] rnd;
    logic [3:0]  region;
    logic [5:0]  idx;
    resp_t       exp_resp;
    wb_data_t    rd;
    resp_t       resp;
    begin_test("timing");
    repeat (16) begin
      rnd    = rand32();
      region = {2'b00, rnd[1:0]};
      idx    = {2'b00, rnd[11:8]};
      exp_resp = RESP_ERR;
      if (region == CLK_CTRL_REGION && idx <= 6'd3) begin
        exp_resp = RESP_ACK;
      end else if (region == PAD_CFG_REGION && idx < 6'd8) begin
        exp_resp = RESP_ACK;
      end
      wb_read(make_addr(region, idx), rd, resp);
      cmp_resp(exp_resp, resp, "mixed read");
    end
    end_test();
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    seed         = 32'h384e;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_name    = "init";
    rst          = 1'b1;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_dat_w     = '0;
    pad_clk_byp  = 1'b0;
    jtag_clk_byp = 1'b0;
    gpio_out     = '0;
    gpio_oe      = '0;
    timer_ch     = '0;
    pad_in       = '0;
    exp_en       = '1;
    exp_byp      = '0;
    for (int k = 0; k < NUM_PADS; k++) begin
      exp_func[k] = PAD_FUNC_GPIO;
    end
    repeat (16) @(negedge soc_clk);
    rst = 1'b0;
    @(negedge soc_clk);

    test_reset_defaults();
    test_clk_regs();
    test_pad_mux();
    test_unmapped();
    test_bad_index();
    test_timing();

    $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed,
             error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- source/chip_ctrl_top.sv
// Chip control top level: Wishbone decoder, clock control target and pad config target
`timescale 1ns/100ps

module chip_ctrl_top import chip_ctrl_pkg::*; (
  input  logic         soc_clk_i,
  input  logic         rst_i,
  // Wishbone classic slave
  input  logic         wb_cyc_i,
  input  logic         wb_stb_i,
  input  logic         wb_we_i,
  input  wb_addr_t     wb_adr_i,
  input  wb_data_t     wb_dat_i,
  output wb_data_t     wb_dat_o,
  output logic         wb_ack_o,
  output logic         wb_err_o,
  // Clock control
  input  logic         pad_clk_byp_i,
  input  logic         jtag_clk_byp_i,
  output clk_dom_vec_t clk_en_o,
  output clk_dom_vec_t clk_byp_o,
  // Pad multiplexer
  input  pad_vec_t     gpio_out_i,
  input  pad_vec_t     gpio_oe_i,
  input  timer_vec_t   timer_ch_i,
  input  pad_vec_t     pad_in_i,
  output pad_vec_t     pad_out_o,
  output pad_vec_t     pad_oe_o,
  output pad_vec_t     gpio_in_o
);

  ////////////////////////////////////////////////////////////
  // Internal target buses
  ////////////////////////////////////////////////////////////
  logic     clk_stb;
  logic     clk_ack;
  logic     clk_err;
  wb_data_t clk_dat;
  logic     pad_stb;
  logic     pad_ack;
  logic     pad_err;
  wb_data_t pad_dat;

  // Region split and response merge
  chip_ctrl_decode i_decode (
    .soc_clk_i ( soc_clk_i ),
    .rst_i     ( rst_i     ),
    .wb_cyc_i  ( wb_cyc_i  ),
    .wb_stb_i  ( wb_stb_i  ),
    .wb_adr_i  ( wb_adr_i  ),
    .clk_ack_i ( clk_ack   ),
    .clk_err_i ( clk_err   ),
    .clk_dat_i ( clk_dat   ),
    .pad_ack_i ( pad_ack   ),
    .pad_err_i ( pad_err   ),
    .pad_dat_i ( pad_dat   ),
    .clk_stb_o ( clk_stb   ),
    .pad_stb_o ( pad_stb   ),
    .wb_dat_o  ( wb_dat_o  ),
    .wb_ack_o  ( wb_ack_o  ),
    .wb_err_o  ( wb_err_o  )
  );

  // Enables and bypass requests for slow, soc and per
  clk_ctrl_regs i_clk_ctrl (
    .soc_clk_i      ( soc_clk_i      ),
    .rst_i          ( rst_i          ),
    .stb_i          ( clk_stb        ),
    .we_i           ( wb_we_i        ),
    .adr_i          ( wb_adr_i       ),
    .dat_i          ( wb_dat_i       ),
    .dat_o          ( clk_dat        ),
    .ack_o          ( clk_ack        ),
    .err_o          ( clk_err        ),
    .pad_clk_byp_i  ( pad_clk_byp_i  ),
    .jtag_clk_byp_i ( jtag_clk_byp_i ),
    .clk_en_o       ( clk_en_o       ),
    .clk_byp_o      ( clk_byp_o      )
  );

  // GPIO or timer per pad
  pad_cfg_regs i_pad_cfg (
    .soc_clk_i  ( soc_clk_i  ),
    .rst_i      ( rst_i      ),
    .stb_i      ( pad_stb    ),
    .we_i       ( wb_we_i    ),
    .adr_i      ( wb_adr_i   ),
    .dat_i      ( wb_dat_i   ),
    .dat_o      ( pad_dat    ),
    .ack_o      ( pad_ack    ),
    .err_o      ( pad_err    ),
    .gpio_out_i ( gpio_out_i ),
    .gpio_oe_i  ( gpio_oe_i  ),
    .timer_ch_i ( timer_ch_i ),
    .gpio_in_o  ( gpio_in_o  ),
    .pad_in_i   ( pad_in_i   ),
    .pad_out_o  ( pad_out_o  ),
    .pad_oe_o   ( pad_oe_o   )
  );

endmodule

//--- source/pad_cfg_regs.sv
// Pad configuration registers: per-pad function select, pad output and input multiplexer
`timescale 1ns/100ps

module pad_cfg_regs import chip_ctrl_pkg::*; (
  input  logic       soc_clk_i,
  input  logic       rst_i,
  // Register port
  input  logic       stb_i,
  input  logic       we_i,
  input  wb_addr_t   adr_i,
  input  wb_data_t   dat_i,
  output wb_data_t   dat_o,
  output logic       ack_o,
  output logic       err_o,
  // Peripheral side
  input  pad_vec_t   gpio_out_i,
  input  pad_vec_t   gpio_oe_i,
  input  timer_vec_t timer_ch_i,
  output pad_vec_t   gpio_in_o,
  // Pad side
  input  pad_vec_t   pad_in_i,
  output pad_vec_t   pad_out_o,
  output pad_vec_t   pad_oe_o
);

  localparam int unsigned FUNC_W = $bits(pad_func_t);

  logic [REG_IDX_W-1:0] idx;
  logic                 idx_valid;
  logic                 accept;
  logic                 ack_q;
  logic                 err_q;
  pad_func_t            pad_func_q [NUM_PADS];

  assign idx = adr_i[REG_IDX_LSB +: REG_IDX_W];

  // One register per pad
  assign idx_valid = (idx < REG_IDX_W'(NUM_PADS));

  // Accept only outside a response cycle
  assign accept = stb_i && !ack_q && !err_q;

  ////////////////////////////////////////////////////////////
  // Function select registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge soc_clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      // Every pad comes up as GPIO
      for (int k = 0; k < NUM_PADS; k++) begin
        pad_func_q[k] <= PAD_FUNC_GPIO;
      end
    end else begin
      ack_q <= accept && idx_valid;
      err_q <= accept && !idx_valid;
      if (accept && we_i) begin
        for (int k = 0; k < NUM_PADS; k++) begin
          if (idx == REG_IDX_W'(k)) begin
            pad_func_q[k] <= dat_i[FUNC_W-1:0];
          end
        end
      end
    end
  end

  assign ack_o = ack_q;
  assign err_o = err_q;

  // Readback of the selected function
  always_comb begin
    dat_o = '0;
    for (int k = 0; k < NUM_PADS; k++) begin
      if (idx == REG_IDX_W'(k)) begin
        dat_o[FUNC_W-1:0] = pad_func_q[k];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Pad multiplexer
  ////////////////////////////////////////////////////////////
  // GPIO: straight through in both directions
  // Timer: channel k mod 4 always driven, gpio_in reads 0
  // Reserved codes: pad released and quiet
  always_comb begin
    for (int k = 0; k < NUM_PADS; k++) begin
      case (pad_func_q[k])
        PAD_FUNC_GPIO: begin
          pad_out_o[k] = gpio_out_i[k];
          pad_oe_o[k]  = gpio_oe_i[k];
          gpio_in_o[k] = pad_in_i[k];
        end
        PAD_FUNC_TIMER: begin
          pad_out_o[k] = timer_ch_i[k % TIMER_CH_COUNT];
          pad_oe_o[k]  = 1'b1;
          gpio_in_o[k] = 1'b0;
        end
        default: begin
          pad_out_o[k] = 1'b0;
          pad_oe_o[k]  = 1'b0;
          gpio_in_o[k] = 1'b0;
        end
      endcase
    end
  end

endmodule

//--- source/clk_ctrl_regs.sv
// Clock control registers: per-domain enable and bypass, global bypass merge, status readback
`timescale 1ns/100ps

module clk_ctrl_regs import chip_ctrl_pkg::*; (
  input  logic         soc_clk_i,
  input  logic         rst_i,
  // Register port
  input  logic         stb_i,
  input  logic         we_i,
  input  wb_addr_t     adr_i,
  input  wb_data_t     dat_i,
  output wb_data_t     dat_o,
  output logic         ack_o,
  output logic         err_o,
  // Global bypass requests
  input  logic         pad_clk_byp_i,
  input  logic         jtag_clk_byp_i,
  // Per-domain controls
  output clk_dom_vec_t clk_en_o,
  output clk_dom_vec_t clk_byp_o
);

  logic [REG_IDX_W-1:0] idx;
  logic                 idx_valid;
  logic                 accept;
  logic                 global_byp;
  logic                 ack_q;
  logic                 err_q;
  clk_dom_vec_t         clk_en_q;
  clk_dom_vec_t         clk_byp_q;

  assign idx = adr_i[REG_IDX_LSB +: REG_IDX_W];

  // Domain registers plus the status word
  assign idx_valid = (idx <= CLK_STATUS_IDX);

  // New request, not while a response is on the bus
  assign accept = stb_i && !ack_q && !err_q;

  ////////////////////////////////////////////////////////////
  // Register file and response
  ////////////////////////////////////////////////////////////
  always_ff @(posedge soc_clk_i) begin
    if (rst_i) begin
      ack_q     <= 1'b0;
      err_q     <= 1'b0;
      clk_en_q  <= '1;
      clk_byp_q <= '0;
    end else begin
      ack_q <= accept && idx_valid;
      err_q <= accept && !idx_valid;
      // Status index falls through the loop, so writes there are dropped
      if (accept && we_i) begin
        for (int d = 0; d < NUM_CLK_DOMAINS; d++) begin
          if (idx == REG_IDX_W'(d)) begin
            clk_en_q[d]  <= dat_i[CLK_EN_BIT];
            clk_byp_q[d] <= dat_i[CLK_BYP_BIT];
          end
        end
      end
    end
  end

  assign ack_o = ack_q;
  assign err_o = err_q;

  ////////////////////////////////////////////////////////////
  // Bypass combination
  ////////////////////////////////////////////////////////////
  // Pad or JTAG forces bypass in every domain
  assign global_byp = pad_clk_byp_i || jtag_clk_byp_i;
  assign clk_byp_o  = clk_byp_q | {NUM_CLK_DOMAINS{global_byp}};
  assign clk_en_o   = clk_en_q;

  // Read mux, address is held through the ack cycle
  always_comb begin
    dat_o = '0;
    for (int d = 0; d < NUM_CLK_DOMAINS; d++) begin
      if (idx == REG_IDX_W'(d)) begin
        dat_o[CLK_EN_BIT]  = clk_en_q[d];
        dat_o[CLK_BYP_BIT] = clk_byp_q[d];
      end
    end
    if (idx == CLK_STATUS_IDX) begin
      dat_o[NUM_CLK_DOMAINS-1:0] = clk_byp_o;
    end
  end

endmodule

//--- source/chip_ctrl_decode.sv
// Wishbone address decoder with target strobes, response merge and default error responder
`timescale 1ns/100ps

module chip_ctrl_decode import chip_ctrl_pkg::*; (
  input  logic     soc_clk_i,
  input  logic     rst_i,
  // Bus side
  input  logic     wb_cyc_i,
  input  logic     wb_stb_i,
  input  wb_addr_t wb_adr_i,
  // Clock control target
  input  logic     clk_ack_i,
  input  logic     clk_err_i,
  input  wb_data_t clk_dat_i,
  // Pad config target
  input  logic     pad_ack_i,
  input  logic     pad_err_i,
  input  wb_data_t pad_dat_i,
  // Strobes to targets
  output logic     clk_stb_o,
  output logic     pad_stb_o,
  // Merged response
  output wb_data_t wb_dat_o,
  output logic     wb_ack_o,
  output logic     wb_err_o
);

  ////////////////////////////////////////////////////////////
  // Region decode
  ////////////////////////////////////////////////////////////
  logic [REGION_W-1:0] region;
  logic                clk_sel;
  logic                pad_sel;
  logic                unmapped_sel;
  logic                req;
  logic                dflt_err_q;

  // Region number straight from the address
  assign region = wb_adr_i[REGION_LSB +: REGION_W];

  assign clk_sel      = (region == CLK_CTRL_REGION);
  assign pad_sel      = (region == PAD_CFG_REGION);
  // Everything else falls to the error responder
  assign unmapped_sel = !clk_sel && !pad_sel;

  // Valid bus cycle
  assign req = wb_cyc_i && wb_stb_i;

  // Target strobes, only during an active cycle
  assign clk_stb_o = req && clk_sel;
  assign pad_stb_o = req && pad_sel;

  ////////////////////////////////////////////////////////////
  // Default error responder
  ////////////////////////////////////////////////////////////
  // One-cycle err after acceptance
  // Held-off while err is shown so the same request is not answered twice
  always_ff @(posedge soc_clk_i) begin
    if (rst_i) begin
      dflt_err_q <= 1'b0;
    end else begin
      dflt_err_q <= req && unmapped_sel && !dflt_err_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response merge
  ////////////////////////////////////////////////////////////
  // At most one source answers at a time
  assign wb_ack_o = clk_ack_i || pad_ack_i;
  assign wb_err_o = clk_err_i || pad_err_i || dflt_err_q;

  // Read data of the addressed target, zero for unmapped
  always_comb begin
    if (clk_sel) begin
      wb_dat_o = clk_dat_i;
    end else if (pad_sel) begin
      wb_dat_o = pad_dat_i;
    end else begin
      wb_dat_o = '0;
    end
  end

endmodule

//--- source/chip_ctrl_pkg.sv
// Chip control package: bus types, domain and pad widths, memory map, register layout
package chip_ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // Wishbone bus
  ////////////////////////////////////////////////////////////
  // Byte address and data word of the chip control port
  typedef logic [31:0] wb_addr_t;
  typedef logic [31:0] wb_data_t;

  ////////////////////////////////////////////////////////////
  // Clock domains
  ////////////////////////////////////////////////////////////
  // Domain order: 0 slow, 1 soc, 2 per
  localparam int unsigned NUM_CLK_DOMAINS = 3;
  typedef logic [NUM_CLK_DOMAINS-1:0] clk_dom_vec_t;

  // Bit positions inside a domain register
  localparam int unsigned CLK_EN_BIT  = 0;
  localparam int unsigned CLK_BYP_BIT = 1;

  ////////////////////////////////////////////////////////////
  // Pads and timer channels
  ////////////////////////////////////////////////////////////
  localparam int unsigned NUM_PADS       = 8;
  localparam int unsigned TIMER_CH_COUNT = 4;
  typedef logic [NUM_PADS-1:0]       pad_vec_t;
  typedef logic [TIMER_CH_COUNT-1:0] timer_vec_t;

  // Pad function select, codes 2 and 3 are reserved
  typedef logic [1:0] pad_func_t;
  localparam pad_func_t PAD_FUNC_GPIO  = 2'd0;
  localparam pad_func_t PAD_FUNC_TIMER = 2'd1;

  ////////////////////////////////////////////////////////////
  // Memory map
  ////////////////////////////////////////////////////////////
  // Region field, address bits 11:8
  localparam int unsigned REGION_LSB = 8;
  localparam int unsigned REGION_W   = 4;
  localparam logic [REGION_W-1:0] CLK_CTRL_REGION = 4'd0;
  localparam logic [REGION_W-1:0] PAD_CFG_REGION  = 4'd1;

  // Word index inside a region, address bits 7:2
  localparam int unsigned REG_IDX_LSB = 2;
  localparam int unsigned REG_IDX_W   = 6;

  // Read-only effective bypass vector in the clock region
  localparam logic [REG_IDX_W-1:0] CLK_STATUS_IDX = 6'd3;

endpackage
